//--- dv/vcxo_discipline_chk.sv
/* vcxo discipline assertions
   detector pair clearing, lock against a missing reference, single cycle ticks */
module vcxo_discipline_chk (
	input logic ref_in,
	input logic osc_1k,
	input logic up,			// detector flags
	input logic dn,
	input logic ref_tick,
	input logic osc_tick,
	input logic lock_n,
	input logic ref_missing
);

	int fails = 0;	// failed assertions so far

	// a completed pair leaves both flags clear on the next cycle
	a_pair_clear: assert property (@(posedge ref_in) disable iff (osc_1k)
		(up && dn) |=> (!up && !dn))
		else
		begin
			$error("up and dn not cleared the cycle after both were set");
			fails++;
		end

	// lock is only gained with a live reference
	a_lock_ref: assert property (@(posedge ref_in) disable iff (osc_1k)
		$fell(lock_n) |-> !ref_missing)
		else
		begin
			$error("lock_n fell while ref_missing was high");
			fails++;
		end

	a_ref_tick: assert property (@(posedge ref_in) disable iff (osc_1k) ref_tick |=> !ref_tick)
		else
		begin
			$error("reference div_tick longer than one cycle");
			fails++;
		end

	a_osc_tick: assert property (@(posedge ref_in) disable iff (osc_1k) osc_tick |=> !osc_tick)
		else
		begin
			$error("vcxo div_tick longer than one cycle");
			fails++;
		end

endmodule

bind vcxo_discipline_top vcxo_discipline_chk chk_u (
	.ref_in      (ref_in),
	.osc_1k      (osc_1k),
	.up          (pfd_u.up),
	.dn          (pfd_u.dn),
	.ref_tick    (ref_tick),
	.osc_tick    (osc_tick),
	.lock_n      (lock_n),
	.ref_missing (ref_missing)
);

//--- dv/vcxo_discipline_mon.sv
/* vcxo discipline monitor
   cycle model of registers, dividers, detector and watchdog, checked against the DUT */
`include "pfd_macros.svh"

module vcxo_discipline_mon (
	input logic                   ref_in,
	input logic                   osc_1k,
	input logic                   ref_sig,
	input logic                   vcxo_sig,
	input logic                   cfg_we,
	input logic [1:0]             cfg_addr,
	input logic [`PFD_REG_DW-1:0] cfg_wdata,
	input logic [`PFD_REG_DW-1:0] cfg_rdata,
	input logic                   loop_drive,
	input logic                   loop_level,
	input logic                   ref_1k,
	input logic                   vcxo_1k,
	input logic                   lock_n,
	input logic                   ref_missing
);

	int errs [4];	// registers, dividers, detector, watchdog
	int m_ref_div, m_osc_div, m_win, m_hold;
	// per channel state, 0 is the reference and 1 the vcxo
	bit s1 [2], s2 [2], s3 [2], edge_q [2], dout [2], dtick [2];
	int cnt [2];
	bit m_up, m_dn;
	int m_wid;		// cycles since the first tick of a pair
	int m_good;		// in-window pairs in a row
	int m_quiet;	// cycles since the last reference edge

	task automatic reset_model();
		for (int ch = 0; ch < 2; ch++)
		begin
			s1[ch]     = 0;
			s2[ch]     = 0;
			s3[ch]     = 0;
			edge_q[ch] = 0;
			dout[ch]   = 0;
			dtick[ch]  = 0;
			cnt[ch]    = 0;
		end
		{m_up, m_dn} = 2'b00;
		m_wid     = 0;
		m_good    = 0;
		m_quiet   = 65535;	// as if the reference were already gone
		m_ref_div = `PFD_REF_DIV_RST;
		m_osc_div = `PFD_OSC_DIV_RST;
		m_win     = `PFD_WINDOW_RST;
		m_hold    = `PFD_HOLDOVER_RST;
	endtask

	task automatic advance_model();
		bit lone_r;
		bit lone_o;
		bit rise;
		bit pair;
		int w;
		int lim;
		lone_r = dtick[0] & ~dtick[1];
		lone_o = dtick[1] & ~dtick[0];
		pair   = 0;
		w      = 0;
		if (m_up && m_dn)
		begin
			{m_up, m_dn} = 2'b00;	// both seen, ticks this cycle are lost
			m_wid = 0;
		end
		else
		begin
			if (m_up != m_dn)
			begin
				pair  = (m_up && lone_o) || (m_dn && lone_r);
				w     = m_wid;
				m_wid = (m_wid < 255) ? m_wid + 1 : 255;
			end
			else if (dtick[0] && dtick[1])
				pair = 1;	// zero width pair, w stays 0
			else if (lone_r || lone_o)
				m_wid = 1;
			m_up = m_up | lone_r;
			m_dn = m_dn | lone_o;
		end
		if (pair)
			m_good = (w > m_win) ? 0 : ((m_good < `PFD_LOCK_COUNT) ? m_good + 1 : m_good);
		if (edge_q[0])
			m_quiet = 0;
		else if (m_quiet < 65535)
			m_quiet++;
		for (int ch = 0; ch < 2; ch++)
		begin
			lim        = ch ? m_osc_div : m_ref_div;
			rise       = s2[ch] & ~s3[ch];
			edge_q[ch] = rise;
			dtick[ch]  = 0;
			if (rise && cnt[ch] >= lim)
			begin
				cnt[ch]   = 0;
				dout[ch]  = ~dout[ch];
				dtick[ch] = dout[ch];	// rising toggle only
			end
			else if (rise)
				cnt[ch]++;
			s3[ch] = s2[ch];
			s2[ch] = s1[ch];
		end
		s1[0] = ref_sig;
		s1[1] = vcxo_sig;
		if (cfg_we)
			case (cfg_addr)
				pfd_pkg::REF_DIV:  m_ref_div = cfg_wdata;
				pfd_pkg::OSC_DIV:  m_osc_div = cfg_wdata & 16'h3fff;
				pfd_pkg::LOCK_WIN: m_win     = cfg_wdata & 16'h00ff;
				default:           m_hold    = cfg_wdata;
			endcase
	endtask

	function automatic logic [31:0] readback(input logic [1:0] addr);
		case (addr)
			pfd_pkg::REF_DIV:  readback = m_ref_div;
			pfd_pkg::OSC_DIV:  readback = m_osc_div;
			pfd_pkg::LOCK_WIN: readback = m_win;
			default:           readback = m_hold;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp, input int cat);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			errs[cat]++;
		end
	endtask

	always @(posedge ref_in or posedge osc_1k)
	begin
		if (osc_1k)
			reset_model();
		else
			advance_model();
	end

	// outputs settle after the rising edge, compare in the middle of the cycle
	always @(negedge ref_in)
	begin
		if (!osc_1k)
		begin
			compare_value("cfg_rdata", cfg_rdata, readback(cfg_addr), 0);
			compare_value("ref_1k", ref_1k, dout[0], 1);
			compare_value("vcxo_1k", vcxo_1k, dout[1], 1);
			compare_value("lock_n", lock_n, m_good != `PFD_LOCK_COUNT, 2);
			compare_value("ref_missing", ref_missing, m_quiet > m_hold, 3);
			compare_value("loop_drive", loop_drive, (m_quiet > m_hold) | (m_up ^ m_dn), 2);
			compare_value("loop_level", loop_level, (m_quiet > m_hold) ? dout[1] : m_up, 2);
		end
	end

endmodule

//--- dv/vcxo_discipline_tb.sv
/* vcxo discipline testbench
   seeded square waves, register traffic, pump direction, lock and holdover phases */
`include "pfd_macros.svh"

module vcxo_discipline_tb;

	localparam int DIV_CYC  = 400;	// per random divide setting
	localparam int RATE_CYC = 600;	// per frequency offset direction
	localparam int LOCK_CYC = 3000;	// bound on lock acquisition
	localparam int STEP_CYC = 600;	// bound on lock loss after the step
	localparam int HOLD_CYC = 800;	// loss, holdover and recovery
	localparam int LIMIT    = 200 + 3 * DIV_CYC + 2 * RATE_CYC + LOCK_CYC + STEP_CYC
		+ HOLD_CYC + 500;

	logic                   ref_in;
	logic                   osc_1k;
	logic                   ref_sig;
	logic                   vcxo_sig;
	logic                   cfg_we;
	pfd_pkg::cfg_addr_e     cfg_addr;
	logic [`PFD_REG_DW-1:0] cfg_wdata;
	logic [`PFD_REG_DW-1:0] cfg_rdata;
	logic                   loop_drive;
	logic                   loop_level;
	logic                   ref_1k;
	logic                   vcxo_1k;
	logic                   lock_n;
	logic                   ref_missing;

	integer seed = 32'h0a83_f75c;
	int cycles = 0;
	int tb_errs = 0;
	int total;
	int ref_half;
	int vcxo_half;
	int jit;
	int lag;
	int ref_left;
	int vcxo_left;
	int up_cyc;		// pump cycles seen at the ports
	int dn_cyc;
	bit ref_run;
	bit follow;			// makes the vcxo a delayed copy of the reference
	logic [31:0] hist;	// bit n is the reference level n cycles back

	vcxo_discipline_top dut (.*);
	vcxo_discipline_mon mon (.*);

	initial ref_in = 1'b0;
	always #20 ref_in = ~ref_in;

	always @(posedge ref_in)
	begin
		cycles++;
		if (cycles > LIMIT)
		begin
			$display("TIMEOUT: run did not finish within %0d cycles", LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	function automatic int pick(input int lo, input int hi);
		pick = lo + ($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	task automatic next_cycle();
		@(posedge ref_in);
		#5;
		if (ref_run && ref_left <= 1)
		begin
			ref_sig  = ~ref_sig;
			ref_left = ref_half + pick(0, jit);
		end
		else if (ref_run)
			ref_left--;
		hist = {hist[30:0], ref_sig};
		if (follow)
			vcxo_sig = hist[lag];
		else if (vcxo_left <= 1)
		begin
			vcxo_sig  = ~vcxo_sig;
			vcxo_left = vcxo_half + pick(0, jit);
		end
		else
			vcxo_left--;
		if (loop_drive && !ref_missing)
		begin
			if (loop_level)
				up_cyc++;
			else
				dn_cyc++;
		end
	endtask

	task automatic write_reg(input pfd_pkg::cfg_addr_e addr, input int data);
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		next_cycle();
		cfg_we    = 1'b0;
	endtask

	task automatic pulse_reset();
		osc_1k = 1'b1;
		repeat (2) next_cycle();
		osc_1k = 1'b0;
	endtask

	task automatic wait_until(input bit on_lock, input bit level, input int bound,
		input string what);
		int n;
		n = 0;
		while ((on_lock ? lock_n : ref_missing) !== level && n < bound)
		begin
			next_cycle();
			n++;
		end
		if ((on_lock ? lock_n : ref_missing) !== level)
		begin
			$display("ERROR at %0t: %s did not happen within %0d cycles", $time, what, bound);
			tb_errs++;
		end
	endtask

	task automatic measure_pump(input int r_half, input int v_half);
		ref_half  = r_half;
		vcxo_half = v_half;
		up_cyc    = 0;
		dn_cyc    = 0;
		repeat (RATE_CYC) next_cycle();
		if ((r_half < v_half) ? (up_cyc <= dn_cyc) : (dn_cyc <= up_cyc))
		begin
			$display("ERROR at %0t: pump went the wrong way for half periods %0d and %0d",
				$time, r_half, v_half);
			tb_errs++;
		end
	endtask

	initial
	begin
		osc_1k    = 1'b1;
		ref_sig   = 1'b0;
		vcxo_sig  = 1'b0;
		cfg_we    = 1'b0;
		cfg_addr  = pfd_pkg::REF_DIV;
		cfg_wdata = '0;
		hist      = '0;
		ref_run   = 1'b0;
		follow    = 1'b0;
		ref_half  = 4;
		vcxo_half = 4;
		jit       = 0;
		lag       = 0;
		ref_left  = 1;
		vcxo_left = 1000000;	// vcxo quiet during register traffic
		pulse_reset();
		// defaults first, then random writes with readback elsewhere
		for (int a = 0; a < 4; a++)
		begin
			cfg_addr = pfd_pkg::cfg_addr_e'(a);
			next_cycle();
		end
		repeat (24)
		begin
			write_reg(pfd_pkg::cfg_addr_e'(pick(0, 3)), pick(0, 65535));
			cfg_addr = pfd_pkg::cfg_addr_e'(pick(0, 3));
			next_cycle();
		end
		write_reg(pfd_pkg::LOCK_WIN, `PFD_WINDOW_RST);
		write_reg(pfd_pkg::HOLDOVER, `PFD_HOLDOVER_RST);
		// dividers with random ratios and free running inputs
		ref_run   = 1'b1;
		jit       = 2;
		vcxo_left = 1;
		repeat (3)
		begin
			write_reg(pfd_pkg::REF_DIV, pick(0, 7));
			write_reg(pfd_pkg::OSC_DIV, pick(0, 7));
			ref_half  = pick(2, 8);
			vcxo_half = pick(2, 8);
			repeat (DIV_CYC) next_cycle();
		end
		// frequency offset both ways
		write_reg(pfd_pkg::REF_DIV, 1);
		write_reg(pfd_pkg::OSC_DIV, 1);
		jit = 1;
		measure_pump(5, 9);
		measure_pump(9, 5);
		// aligned inputs from a fresh reset, then a phase step on the vcxo
		ref_half = 8;
		jit      = 2;
		follow   = 1'b1;
		lag      = pick(0, 2);
		pulse_reset();
		wait_until(1'b1, 1'b0, LOCK_CYC, "lock with aligned inputs");
		repeat (10)
		begin
			lag++;	// vcxo holds its level while the delay grows
			next_cycle();
		end
		wait_until(1'b1, 1'b1, STEP_CYC, "lock loss after the phase step");
		// reference stops, holdover, reference returns
		follow    = 1'b0;
		vcxo_half = 8;
		vcxo_left = 8;
		ref_run   = 1'b0;
		wait_until(1'b0, 1'b1, 400, "ref_missing after the reference stopped");
		repeat (300) next_cycle();
		ref_run = 1'b1;
		wait_until(1'b0, 1'b0, 100, "ref_missing clear after the reference returned");
		repeat (20) next_cycle();
		total = mon.errs[0] + mon.errs[1] + mon.errs[2] + mon.errs[3]
			+ dut.chk_u.fails + tb_errs;
		$display("errors: regs %0d dividers %0d detector %0d watchdog %0d asserts %0d flow %0d",
			mon.errs[0], mon.errs[1], mon.errs[2], mon.errs[3], dut.chk_u.fails, tb_errs);
		if (total == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+logic
logic/pfd_pkg.sv
logic/edge_divider.sv
logic/phase_detector.sv
logic/ref_watchdog.sv
logic/loop_regs.sv
logic/vcxo_discipline_top.sv
dv/vcxo_discipline_mon.sv
dv/vcxo_discipline_chk.sv
dv/vcxo_discipline_tb.sv

//--- logic/edge_divider.sv
/* edge divider
   synchronizes a slow square wave, finds its rising edges and divides them down */
module edge_divider #(
	parameter type cnt_t = logic [7:0]	// counter type, sized per input
) (
	input  logic ref_in,	// system clock
	input  logic osc_1k,	// async reset, active high
	input  logic sig_in,	// slow input, not yet synchronous
	input  cnt_t div,		// toggle on every (div + 1)th edge
	output logic sig_edge,	// one pulse per synchronized rising edge
	output logic div_out,	// divided square wave
	output logic div_tick	// high for the cycle div_out goes high
);

	logic sync_1;
	logic sync_2;
	logic sync_3;	// delayed copy for edge detection
	logic rise;
	logic last;		// this edge completes a count
	cnt_t cnt;

	assign rise = sync_2 & ~sync_3;
	// >= so a divide lowered under the running count cannot strand it
	assign last = (cnt >= div);

	// two flop synchronizer plus edge register
	always_ff @(posedge ref_in or posedge osc_1k)
	begin
		if (osc_1k)
		begin
			sync_1   <= 1'b0;
			sync_2   <= 1'b0;
			sync_3   <= 1'b0;
			sig_edge <= 1'b0;
		end
		else
		begin
			sync_1   <= sig_in;
			sync_2   <= sync_1;
			sync_3   <= sync_2;
			sig_edge <= rise;	// lands 3 cycles after the input edge
		end
	end

	// divider updates on the same edge that registers sig_edge
	always_ff @(posedge ref_in or posedge osc_1k)
	begin
		if (osc_1k)
		begin
			cnt      <= '0;
			div_out  <= 1'b0;
			div_tick <= 1'b0;
		end
		else
		begin
			div_tick <= rise & last & ~div_out;	// only the low to high toggle
			if (rise)
			begin
				if (last)
				begin
					cnt     <= '0;
					div_out <= ~div_out;
				end
				else
					cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

//--- logic/loop_regs.sv
/* loop configuration registers
   strobe written divide values, lock window and holdover time with readback */
`include "pfd_macros.svh"

module loop_regs (
	input  logic                   ref_in,		// system clock
	input  logic                   osc_1k,		// async reset, active high
	input  logic                   cfg_we,		// write strobe
	input  pfd_pkg::cfg_addr_e     cfg_addr,	// register select
	input  logic [`PFD_REG_DW-1:0] cfg_wdata,
	output logic [`PFD_REG_DW-1:0] cfg_rdata,	// follows cfg_addr
	output pfd_pkg::ref_div_t      ref_div,
	output pfd_pkg::osc_div_t      osc_div,
	output pfd_pkg::win_t          lock_win,
	output logic [`PFD_REG_DW-1:0] holdover
);

	localparam int REF_W = $bits(pfd_pkg::ref_div_t);
	localparam int OSC_W = $bits(pfd_pkg::osc_div_t);
	localparam int WIN_W = $bits(pfd_pkg::win_t);

	// writes land on the sampling edge, visible the next cycle
	always_ff @(posedge ref_in or posedge osc_1k)
	begin
		if (osc_1k)
		begin
			ref_div  <= `PFD_REF_DIV_RST;
			osc_div  <= `PFD_OSC_DIV_RST;
			lock_win <= `PFD_WINDOW_RST;
			holdover <= `PFD_HOLDOVER_RST;
		end
		else if (cfg_we)
		begin
			case (cfg_addr)
				pfd_pkg::REF_DIV:  ref_div  <= cfg_wdata[REF_W-1:0];
				pfd_pkg::OSC_DIV:  osc_div  <= cfg_wdata[OSC_W-1:0];	// top bits dropped
				pfd_pkg::LOCK_WIN: lock_win <= cfg_wdata[WIN_W-1:0];
				pfd_pkg::HOLDOVER: holdover <= cfg_wdata;
				default:           ;
			endcase
		end
	end

	// readback, zero extended to the bus width
	always_comb
	begin
		cfg_rdata = '0;
		case (cfg_addr)
			pfd_pkg::REF_DIV:  cfg_rdata[REF_W-1:0] = ref_div;
			pfd_pkg::OSC_DIV:  cfg_rdata[OSC_W-1:0] = osc_div;
			pfd_pkg::LOCK_WIN: cfg_rdata[WIN_W-1:0] = lock_win;
			pfd_pkg::HOLDOVER: cfg_rdata            = holdover;
			default:           cfg_rdata            = '0;
		endcase
	end

endmodule

//--- logic/pfd_macros.svh
/* vcxo discipline constants
   register width, lock qualification and power-up register values */
`ifndef PFD_MACROS_SVH
`define PFD_MACROS_SVH

// config bus data width
`define PFD_REG_DW 16

// in-window pairs in a row before lock_n drops
`define PFD_LOCK_COUNT 8

// reference divide, toggles on every 5th edge
`define PFD_REF_DIV_RST 16'd4

// vcxo divide, same ratio as the reference at power up
`define PFD_OSC_DIV_RST 14'd4

// widest phase error still counted as good, in ref_in cycles
`define PFD_WINDOW_RST 8'd6

// ref_in cycles without a reference edge before holdover kicks in
`define PFD_HOLDOVER_RST 16'd200

`endif

//--- logic/pfd_pkg.sv
/* vcxo discipline types
   register map and counter widths shared by the loop blocks */
package pfd_pkg;

	// register map of the config port
	typedef enum logic [1:0]
	{
		REF_DIV  = 2'd0,	// reference divide value
		OSC_DIV  = 2'd1,	// vcxo divide value
		LOCK_WIN = 2'd2,	// lock window
		HOLDOVER = 2'd3		// reference timeout
	} cfg_addr_e;

	// reference side divider count
	typedef logic [15:0] ref_div_t;

	// vcxo side divider count, the vcxo runs slower than the reference
	typedef logic [13:0] osc_div_t;

	// phase error width in ref_in cycles
	typedef logic [7:0] win_t;

endpackage

//--- logic/phase_detector.sv
/* tri-state phase frequency detector
   up/dn flags from the divided ticks, phase error width and lock qualification */
`include "pfd_macros.svh"

module phase_detector (
	input  logic          ref_in,		// system clock
	input  logic          osc_1k,		// async reset, active high
	input  logic          ref_tick,		// divided reference rising edge
	input  logic          osc_tick,		// divided vcxo rising edge
	input  pfd_pkg::win_t lock_win,		// widest good phase error
	output logic          pfd_drive,	// output enable to the loop filter
	output logic          pfd_level,	// high pumps up, low pumps down
	output logic          lock_n		// low while locked
);

	localparam int GOOD_W = $clog2(`PFD_LOCK_COUNT + 1);

	logic              up;
	logic              dn;
	logic              set_up;		// a lone reference tick
	logic              set_dn;		// a lone vcxo tick
	logic              idle;
	logic              close;		// second tick of a pair
	logic              coincide;	// both ticks together, zero width pair
	logic              pair_done;
	pfd_pkg::win_t     width;		// cycles since the first tick
	pfd_pkg::win_t     pair_width;
	logic [GOOD_W-1:0] good_cnt;

	assign set_up    = ref_tick & ~osc_tick;
	assign set_dn    = osc_tick & ~ref_tick;
	assign idle      = ~up & ~dn;
	assign close     = (up & ~dn & set_dn) | (dn & ~up & set_up);
	assign coincide  = ref_tick & osc_tick & idle;
	assign pair_done = close | coincide;
	assign pair_width = close ? width : '0;

	// charge pump view of the flags
	assign pfd_drive = up ^ dn;		// tri-stated when idle or clearing
	assign pfd_level = up;
	assign lock_n    = (good_cnt != GOOD_W'(`PFD_LOCK_COUNT));

	// three state detector
	always_ff @(posedge ref_in or posedge osc_1k)
	begin
		if (osc_1k)
		begin
			up <= 1'b0;
			dn <= 1'b0;
		end
		else if (up & dn)
		begin
			up <= 1'b0;	// both seen, reset the pair
			dn <= 1'b0;
		end
		else
		begin
			if (set_up)
				up <= 1'b1;
			if (set_dn)
				dn <= 1'b1;
		end
	end

	// phase error width, saturates at the top of win_t
	always_ff @(posedge ref_in or posedge osc_1k)
	begin
		if (osc_1k)
			width <= '0;
		else if (coincide)
			width <= '0;
		else if (idle & (set_up | set_dn))
			width <= pfd_pkg::win_t'(1);	// first tick opens the pair
		else if (up ^ dn)
			width <= (width == '1) ? width : width + 1'b1;
		else
			width <= '0;
	end

	// lock qualification
	always_ff @(posedge ref_in or posedge osc_1k)
	begin
		if (osc_1k)
			good_cnt <= '0;
		else if (pair_done)
		begin
			if (pair_width > lock_win)
				good_cnt <= '0;		// one wide pair drops lock at once
			else if (good_cnt != GOOD_W'(`PFD_LOCK_COUNT))
				good_cnt <= good_cnt + 1'b1;
		end
	end

endmodule

//--- logic/ref_watchdog.sv
/* reference watchdog
   flags a missing reference when its edges stop for longer than the holdover time */
`include "pfd_macros.svh"

module ref_watchdog (
	input  logic                   ref_in,		// system clock
	input  logic                   osc_1k,		// async reset, active high
	input  logic                   sig_edge,	// synchronized reference edge
	input  logic [`PFD_REG_DW-1:0] holdover,	// timeout in ref_in cycles
	output logic                   ref_missing	// high while the reference is absent
);

	logic [`PFD_REG_DW-1:0] quiet_cnt;	// cycles since the last edge
	logic                   at_top;

	assign at_top = (quiet_cnt == '1);

	// restarts on every edge, otherwise creeps up and parks at the top
	always_ff @(posedge ref_in or posedge osc_1k)
	begin
		if (osc_1k)
			quiet_cnt <= '1;	// start out as if the reference were gone
		else if (sig_edge)
			quiet_cnt <= '0;
		else if (!at_top)
			quiet_cnt <= quiet_cnt + 1'b1;
	end

	// clears the cycle after the first edge that arrives
	assign ref_missing = (quiet_cnt > holdover);

endmodule

//--- logic/vcxo_discipline_top.sv
/* vcxo discipline loop
   divides reference and vcxo, compares them and picks what feeds the loop filter */
`include "pfd_macros.svh"

module vcxo_discipline_top (
	input  logic                   ref_in,		// fast system clock
	input  logic                   osc_1k,		// async reset, active high
	input  logic                   ref_sig,		// reference square wave
	input  logic                   vcxo_sig,	// vcxo square wave
	input  logic                   cfg_we,
	input  pfd_pkg::cfg_addr_e     cfg_addr,
	input  logic [`PFD_REG_DW-1:0] cfg_wdata,
	output logic [`PFD_REG_DW-1:0] cfg_rdata,
	output logic                   loop_drive,	// enable toward the loop filter
	output logic                   loop_level,	// level toward the loop filter
	output logic                   ref_1k,		// divided reference
	output logic                   vcxo_1k,		// divided vcxo
	output logic                   lock_n,		// low when locked
	output logic                   ref_missing	// high in holdover
);

	pfd_pkg::ref_div_t      ref_div;
	pfd_pkg::osc_div_t      osc_div;
	pfd_pkg::win_t          lock_win;
	logic [`PFD_REG_DW-1:0] holdover;
	logic                   ref_edge;	// raw synchronized reference edge
	logic                   ref_tick;
	logic                   osc_tick;
	logic                   pfd_drive;
	logic                   pfd_level;

	loop_regs regs_u (
		.ref_in    (ref_in),
		.osc_1k    (osc_1k),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.ref_div   (ref_div),
		.osc_div   (osc_div),
		.lock_win  (lock_win),
		.holdover  (holdover)
	);

	edge_divider #(.cnt_t(pfd_pkg::ref_div_t)) ref_div_u (
		.ref_in   (ref_in),
		.osc_1k   (osc_1k),
		.sig_in   (ref_sig),
		.div      (ref_div),
		.sig_edge (ref_edge),
		.div_out  (ref_1k),
		.div_tick (ref_tick)
	);

	// vcxo edges are not watched, only the divided tick is used
	edge_divider #(.cnt_t(pfd_pkg::osc_div_t)) osc_div_u (
		.ref_in   (ref_in),
		.osc_1k   (osc_1k),
		.sig_in   (vcxo_sig),
		.div      (osc_div),
		.sig_edge (),
		.div_out  (vcxo_1k),
		.div_tick (osc_tick)
	);

	phase_detector pfd_u (
		.ref_in    (ref_in),
		.osc_1k    (osc_1k),
		.ref_tick  (ref_tick),
		.osc_tick  (osc_tick),
		.lock_win  (lock_win),
		.pfd_drive (pfd_drive),
		.pfd_level (pfd_level),
		.lock_n    (lock_n)
	);

	ref_watchdog wdog_u (
		.ref_in      (ref_in),
		.osc_1k      (osc_1k),
		.sig_edge    (ref_edge),
		.holdover    (holdover),
		.ref_missing (ref_missing)
	);

	// in holdover the 50% vcxo square wave parks the control voltage at mid rail
	assign loop_drive = ref_missing ? 1'b1 : pfd_drive;
	assign loop_level = ref_missing ? vcxo_1k : pfd_level;

endmodule
